// ==== i2c_host_regs.f ====
verilog/i2c_host_pkg.sv
verilog/stream_fifo.sv
verilog/wb_reg_ctrl.sv
verilog/status_flags.sv
verilog/i2c_host_regs.sv
verification/i2c_host_regs_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vi2c_host_regs_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST OK$$" sim.log

$(SIM): i2c_host_regs.f $(wildcard verilog/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert --top-module i2c_host_regs_tb \
		-f i2c_host_regs.f -o Vi2c_host_regs_tb

clean:
	rm -rf obj_dir sim.log

// ==== verification/i2c_host_regs_tb.sv ====
// Testbench for the I2C host register block
// Host bus tasks, bus engine stream model, checking assertions
`timescale 1ns/1ps
`default_nettype none

module i2c_host_regs_tb;

    localparam int TIMEOUT = 64;

    logic        clk;
    logic        rst;
    logic [2:0]  wbs_adr_i;
    logic [15:0] wbs_dat_i;
    logic [15:0] wbs_dat_o;
    logic        wbs_we_i;
    logic [1:0]  wbs_sel_i;
    logic        wbs_stb_i;
    logic        wbs_cyc_i;
    logic        wbs_ack_o;
    logic [6:0]  cmd_address_o;
    logic        cmd_start_o;
    logic        cmd_read_o;
    logic        cmd_write_o;
    logic        cmd_write_multiple_o;
    logic        cmd_stop_o;
    logic        cmd_valid_o;
    logic        cmd_ready_i;
    logic [7:0]  wr_data_o;
    logic        wr_last_o;
    logic        wr_valid_o;
    logic        wr_ready_i;
    logic [7:0]  rd_data_i;
    logic        rd_last_i;
    logic        rd_valid_i;
    logic        rd_ready_o;
    logic        busy_i;
    logic        bus_control_i;
    logic        bus_active_i;
    logic        missed_ack_i;
    logic [15:0] prescale_o;
    logic [15:0] status_o;

    // Run bookkeeping
    int          seed;
    int          errors;
    int          tests;
    int          failed_tests;
    int          errors_at_start;
    string       test_name;

    i2c_host_regs #(
        .DEFAULT_PRESCALE(16'd100),
        .CMD_FIFO_DEPTH(4),
        .WRITE_FIFO_DEPTH(4),
        .READ_FIFO_DEPTH(4)
    ) i2c_host_regs_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Engine must see a stable command until it takes it
    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid_o && !cmd_ready_i) |=> cmd_valid_o)
        else begin
            $display("command valid dropped before ready in test %s", test_name);
            errors++;
        end

    // Ack only answers a live cycle
    a_ack_live: assert property (@(posedge clk) disable iff (rst)
        $rose(wbs_ack_o) |-> $past(wbs_cyc_i && wbs_stb_i))
        else begin
            $display("acknowledge raised outside a bus cycle in test %s", test_name);
            errors++;
        end

    function automatic logic [7:0] next_byte();
        return 8'($random(seed));
    endfunction

    task automatic check_word(input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        if (errors == errors_at_start) begin
            $display("test %s passed", test_name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // Ends on the falling edge where ack is seen
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wbs_ack_o && cycles < TIMEOUT);
        if (!wbs_ack_o) begin
            $display("timeout waiting for bus acknowledge in test %s", test_name);
            errors++;
        end
    endtask

    task automatic bus_access(input logic [2:0] adr, input logic [15:0] dat,
                              input logic [1:0] sel, input logic we);
        @(negedge clk);
        wbs_adr_i = adr;
        wbs_dat_i = dat;
        wbs_sel_i = sel;
        wbs_we_i  = we;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wait_ack();
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [15:0] dat,
                             input logic [1:0] sel);
        bus_access(adr, dat, sel, 1'b1);
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [15:0] dat);
        bus_access(adr, 16'h0000, 2'b11, 1'b0);
        dat = wbs_dat_o;
    endtask

    // Engine takes one command and repacks it in register layout
    task automatic take_cmd(output logic [15:0] word);
        int cycles;
        cycles = 0;
        while (!cmd_valid_o && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cmd_valid_o) begin
            $display("timeout waiting for a command in test %s", test_name);
            errors++;
        end
        word = {3'b000, cmd_stop_o, cmd_write_multiple_o, cmd_write_o, cmd_read_o,
                cmd_start_o, 1'b0, cmd_address_o};
        cmd_ready_i = 1'b1;
        @(negedge clk);
        cmd_ready_i = 1'b0;
    endtask

    task automatic take_write(output logic [7:0] data, output logic last);
        int cycles;
        cycles = 0;
        while (!wr_valid_o && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wr_valid_o) begin
            $display("timeout waiting for a write byte in test %s", test_name);
            errors++;
        end
        data = wr_data_o;
        last = wr_last_o;
        wr_ready_i = 1'b1;
        @(negedge clk);
        wr_ready_i = 1'b0;
    endtask

    // Engine hands over one received byte
    task automatic feed_read(input logic [7:0] data, input logic last);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rd_ready_o && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rd_ready_o) begin
            $display("timeout waiting for read stream ready in test %s", test_name);
            errors++;
        end
        rd_data_i  = data;
        rd_last_i  = last;
        rd_valid_i = 1'b1;
        @(negedge clk);
        rd_valid_i = 1'b0;
    endtask

    initial begin
        logic [15:0] rd;
        logic [7:0]  b;
        logic        l;
        logic [7:0]  exp_b [4];
        logic        exp_l [4];
        int          n;
        seed         = 32'h17a5_5966;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        test_name    = "init";
        rst          = 1'b1;
        wbs_adr_i    = 3'd0;
        wbs_dat_i    = 16'h0000;
        wbs_we_i     = 1'b0;
        wbs_sel_i    = 2'b00;
        wbs_stb_i    = 1'b0;
        wbs_cyc_i    = 1'b0;
        cmd_ready_i  = 1'b0;
        wr_ready_i   = 1'b0;
        rd_data_i    = 8'h00;
        rd_last_i    = 1'b0;
        rd_valid_i   = 1'b0;
        busy_i        = 1'b0;
        bus_control_i = 1'b0;
        bus_active_i  = 1'b0;
        missed_ack_i  = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Only the three empty bits 8, 11 and 14
        start_test("reset");
        bus_read(3'd0, rd);
        check_word(16'h4900, rd);
        bus_read(3'd6, rd);
        check_word(16'd100, rd);
        check_word(16'd100, prescale_o);
        check_word(16'h0000, {14'b0, cmd_valid_o, wr_valid_o});
        finish_test();

        // Low byte write keeps the zero high byte of 16'h0064
        start_test("prescale");
        bus_write(3'd6, 16'h3456, 2'b01);
        bus_read(3'd6, rd);
        check_word(16'h0056, rd);
        check_word(16'h0056, prescale_o);
        bus_write(3'd6, 16'hbeef, 2'b11);
        bus_read(3'd6, rd);
        check_word(16'hbeef, rd);
        check_word(16'hbeef, prescale_o);
        finish_test();

        // Start, write and stop to address 7'h50
        start_test("command");
        bus_write(3'd2, 16'h1550, 2'b11);
        bus_read(3'd2, rd);
        check_word(16'h1550, rd);
        take_cmd(rd);
        check_word(16'h1550, rd);
        // Read and write-multiple to address 7'h2d
        bus_write(3'd2, 16'h0a2d, 2'b11);
        bus_read(3'd2, rd);
        check_word(16'h0a2d, rd);
        take_cmd(rd);
        check_word(16'h0a2d, rd);
        check_word(16'h0000, {15'b0, cmd_valid_o});
        // Command without flags stays out of the queue
        bus_write(3'd2, 16'h0023, 2'b11);
        repeat (4) @(negedge clk);
        check_word(16'h0000, {15'b0, cmd_valid_o});
        bus_read(3'd2, rd);
        check_word(16'h0023, rd);
        finish_test();

        // Last needs both bytes enabled and bit 9
        start_test("write_data");
        for (int i = 0; i < 3; i++) begin
            exp_b[i] = next_byte();
        end
        exp_l[0] = 1'b1;
        exp_l[1] = 1'b0;
        exp_l[2] = 1'b0;
        bus_write(3'd4, {6'b0, 1'b1, 1'b0, exp_b[0]}, 2'b11);
        bus_write(3'd4, {6'b0, 1'b1, 1'b0, exp_b[1]}, 2'b01);
        bus_write(3'd4, {6'b0, 1'b0, 1'b0, exp_b[2]}, 2'b11);
        for (int i = 0; i < 3; i++) begin
            take_write(b, l);
            check_word({7'b0, exp_l[i], exp_b[i]}, {7'b0, l, b});
        end
        check_word(16'h0000, {15'b0, wr_valid_o});
        finish_test();

        // Fifth byte is dropped while the engine stalls
        start_test("write_ovf");
        for (int i = 0; i < 5; i++) begin
            b = next_byte();
            if (i < 4) begin
                exp_b[i] = b;
            end
            bus_write(3'd4, {8'h00, b}, 2'b01);
        end
        bus_read(3'd0, rd);
        check_word(16'h7100, rd);
        n = 0;
        while (wr_valid_o && n < 8) begin
            take_write(b, l);
            if (n < 4) begin
                check_word({8'h00, exp_b[n]}, {8'h00, b});
            end
            n++;
        end
        check_word(16'd4, 16'(n));
        bus_write(3'd0, 16'h2000, 2'b10);
        bus_read(3'd0, rd);
        check_word(16'h4900, rd);
        finish_test();

        // Start commands with the loop index as address
        start_test("cmd_ovf");
        for (int i = 0; i < 5; i++) begin
            bus_write(3'd2, 16'h0100 | 16'(i), 2'b11);
        end
        bus_read(3'd0, rd);
        check_word(16'h4e00, rd);
        n = 0;
        while (cmd_valid_o && n < 8) begin
            take_cmd(rd);
            check_word(16'h0100 | 16'(n), rd);
            n++;
        end
        check_word(16'd4, 16'(n));
        bus_write(3'd0, 16'h0400, 2'b10);
        bus_read(3'd0, rd);
        check_word(16'h4900, rd);
        finish_test();

        // Full read FIFO holds the engine off with ready low
        start_test("read_data");
        for (int i = 0; i < 4; i++) begin
            exp_b[i] = next_byte();
            b        = next_byte();
            exp_l[i] = b[0];
            feed_read(exp_b[i], exp_l[i]);
        end
        check_word(16'h0000, {15'b0, rd_ready_o});
        bus_read(3'd0, rd);
        check_word(16'h8900, rd);
        for (int i = 0; i < 4; i++) begin
            bus_read(3'd4, rd);
            check_word({6'b0, exp_l[i], 1'b1, exp_b[i]}, rd);
        end
        bus_read(3'd4, rd);
        check_word(16'h0000, {15'b0, rd[8]});
        finish_test();

        // Sticky bit 3 next to the live engine levels
        start_test("missed_ack");
        @(negedge clk);
        busy_i       = 1'b1;
        bus_active_i = 1'b1;
        missed_ack_i = 1'b1;
        @(negedge clk);
        missed_ack_i = 1'b0;
        bus_read(3'd0, rd);
        check_word(16'h490d, rd);
        bus_read(3'd0, rd);
        check_word(16'h490d, rd);
        bus_write(3'd0, 16'h0008, 2'b01);
        bus_read(3'd0, rd);
        check_word(16'h4905, rd);
        busy_i        = 1'b0;
        bus_active_i  = 1'b0;
        bus_control_i = 1'b1;
        bus_read(3'd0, rd);
        check_word(16'h4902, rd);
        check_word(16'h4902, status_o);
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/i2c_host_regs.sv ====
// Top level of the I2C host register block
// Register control, command/write/read FIFOs and status flags
`timescale 1ns/1ps
`default_nettype none

module i2c_host_regs #(
    parameter i2c_host_pkg::reg_word_t DEFAULT_PRESCALE = 16'd1,
    parameter int CMD_FIFO_DEPTH   = 32,
    parameter int WRITE_FIFO_DEPTH = 32,
    parameter int READ_FIFO_DEPTH  = 32
) (
    input  wire logic               clk,
    input  wire logic               rst,

    // Host bus
    input  wire logic [2:0]         wbs_adr_i,
    input  wire logic [15:0]        wbs_dat_i,
    output logic [15:0]             wbs_dat_o,
    input  wire logic               wbs_we_i,
    input  wire logic [1:0]         wbs_sel_i,
    input  wire logic               wbs_stb_i,
    input  wire logic               wbs_cyc_i,
    output logic                    wbs_ack_o,

    // Command stream to the engine
    output i2c_host_pkg::i2c_addr_t cmd_address_o,
    output logic                    cmd_start_o,
    output logic                    cmd_read_o,
    output logic                    cmd_write_o,
    output logic                    cmd_write_multiple_o,
    output logic                    cmd_stop_o,
    output logic                    cmd_valid_o,
    input  wire logic               cmd_ready_i,

    // Write byte stream to the engine
    output logic [7:0]              wr_data_o,
    output logic                    wr_last_o,
    output logic                    wr_valid_o,
    input  wire logic               wr_ready_i,

    // Read byte stream from the engine
    input  wire logic [7:0]         rd_data_i,
    input  wire logic               rd_last_i,
    input  wire logic               rd_valid_i,
    output logic                    rd_ready_o,

    // Engine status
    input  wire logic               busy_i,
    input  wire logic               bus_control_i,
    input  wire logic               bus_active_i,
    input  wire logic               missed_ack_i,

    output i2c_host_pkg::reg_word_t prescale_o,
    output i2c_host_pkg::reg_word_t status_o
);

    i2c_host_pkg::cmd_t  cmd_entry, cmd_head;
    i2c_host_pkg::data_t wr_entry, wr_head;
    i2c_host_pkg::data_t rd_entry, rd_head;
    logic cmd_push, wr_push, rd_pop, rd_head_valid;
    logic cmd_empty, cmd_full, cmd_ovf;
    logic wr_empty, wr_full, wr_ovf;
    logic rd_empty, rd_full;
    logic clr_miss_ack, clr_cmd_ovf, clr_wr_ovf;

    // Engine stream field mapping
    assign cmd_address_o        = cmd_head.address;
    assign cmd_start_o          = cmd_head.start;
    assign cmd_read_o           = cmd_head.read;
    assign cmd_write_o          = cmd_head.write;
    assign cmd_write_multiple_o = cmd_head.write_multiple;
    assign cmd_stop_o           = cmd_head.stop;
    assign wr_data_o            = wr_head.data;
    assign wr_last_o            = wr_head.last;
    assign rd_entry.data        = rd_data_i;
    assign rd_entry.last        = rd_last_i;
    // Engine holds its byte while the read FIFO is full
    assign rd_ready_o           = !rd_full;

    wb_reg_ctrl #(.DEFAULT_PRESCALE(DEFAULT_PRESCALE)) ctrl_i (
        .clk, .rst, .wbs_adr_i, .wbs_dat_i, .wbs_dat_o, .wbs_we_i, .wbs_sel_i,
        .wbs_stb_i, .wbs_cyc_i, .wbs_ack_o,
        .status_word_i(status_o), .rd_entry_i(rd_head), .rd_valid_i(rd_head_valid),
        .cmd_push_o(cmd_push), .cmd_entry_o(cmd_entry),
        .wr_push_o(wr_push), .wr_entry_o(wr_entry), .rd_pop_o(rd_pop), .prescale_o,
        .clr_miss_ack_o(clr_miss_ack), .clr_cmd_ovf_o(clr_cmd_ovf),
        .clr_wr_ovf_o(clr_wr_ovf)
    );

    stream_fifo #(.DEPTH(CMD_FIFO_DEPTH), .payload_t(i2c_host_pkg::cmd_t)) cmd_fifo (
        .clk, .rst, .push_i(cmd_push), .data_i(cmd_entry),
        .data_o(cmd_head), .valid_o(cmd_valid_o), .ready_i(cmd_ready_i),
        .full_o(cmd_full), .empty_o(cmd_empty), .overflow_o(cmd_ovf)
    );

    stream_fifo #(.DEPTH(WRITE_FIFO_DEPTH), .payload_t(i2c_host_pkg::data_t)) write_fifo (
        .clk, .rst, .push_i(wr_push), .data_i(wr_entry),
        .data_o(wr_head), .valid_o(wr_valid_o), .ready_i(wr_ready_i),
        .full_o(wr_full), .empty_o(wr_empty), .overflow_o(wr_ovf)
    );

    // Read side never overflows, the engine sees ready low instead
    stream_fifo #(.DEPTH(READ_FIFO_DEPTH), .payload_t(i2c_host_pkg::data_t)) read_fifo (
        .clk, .rst, .push_i(rd_valid_i), .data_i(rd_entry),
        .data_o(rd_head), .valid_o(rd_head_valid), .ready_i(rd_pop),
        .full_o(rd_full), .empty_o(rd_empty), .overflow_o()
    );

    status_flags flags_i (
        .clk, .rst, .busy_i, .bus_control_i, .bus_active_i, .missed_ack_i,
        .cmd_overflow_i(cmd_ovf), .wr_overflow_i(wr_ovf),
        .clr_miss_ack_i(clr_miss_ack), .clr_cmd_ovf_i(clr_cmd_ovf),
        .clr_wr_ovf_i(clr_wr_ovf),
        .cmd_empty_i(cmd_empty), .cmd_full_i(cmd_full),
        .wr_empty_i(wr_empty), .wr_full_i(wr_full),
        .rd_empty_i(rd_empty), .rd_full_i(rd_full),
        .status_word_o(status_o)
    );

endmodule

`default_nettype wire

// ==== verilog/status_flags.sv ====
// Sticky missed-ack and overflow flags with write-one-to-clear
// Packing of the host status word
`timescale 1ns/1ps
`default_nettype none

module status_flags (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               busy_i,
    input  wire logic               bus_control_i,
    input  wire logic               bus_active_i,
    input  wire logic               missed_ack_i,
    input  wire logic               cmd_overflow_i,
    input  wire logic               wr_overflow_i,
    input  wire logic               clr_miss_ack_i,
    input  wire logic               clr_cmd_ovf_i,
    input  wire logic               clr_wr_ovf_i,
    input  wire logic               cmd_empty_i,
    input  wire logic               cmd_full_i,
    input  wire logic               wr_empty_i,
    input  wire logic               wr_full_i,
    input  wire logic               rd_empty_i,
    input  wire logic               rd_full_i,
    output i2c_host_pkg::reg_word_t status_word_o
);

    logic miss_ack_q;
    logic cmd_ovf_q;
    logic wr_ovf_q;

    // Raising event beats a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            miss_ack_q <= 1'b0;
            cmd_ovf_q  <= 1'b0;
            wr_ovf_q   <= 1'b0;
        end else begin
            miss_ack_q <= missed_ack_i || (miss_ack_q && !clr_miss_ack_i);
            cmd_ovf_q  <= cmd_overflow_i || (cmd_ovf_q && !clr_cmd_ovf_i);
            wr_ovf_q   <= wr_overflow_i || (wr_ovf_q && !clr_wr_ovf_i);
        end
    end

    // Bits 7..4 read as zero
    always_comb begin
        status_word_o                            = '0;
        status_word_o[i2c_host_pkg::ST_BUSY]      = busy_i;
        status_word_o[i2c_host_pkg::ST_BUS_CONT]  = bus_control_i;
        status_word_o[i2c_host_pkg::ST_BUS_ACT]   = bus_active_i;
        status_word_o[i2c_host_pkg::ST_MISS_ACK]  = miss_ack_q;
        status_word_o[i2c_host_pkg::ST_CMD_EMPTY] = cmd_empty_i;
        status_word_o[i2c_host_pkg::ST_CMD_FULL]  = cmd_full_i;
        status_word_o[i2c_host_pkg::ST_CMD_OVF]   = cmd_ovf_q;
        status_word_o[i2c_host_pkg::ST_WR_EMPTY]  = wr_empty_i;
        status_word_o[i2c_host_pkg::ST_WR_FULL]   = wr_full_i;
        status_word_o[i2c_host_pkg::ST_WR_OVF]    = wr_ovf_q;
        status_word_o[i2c_host_pkg::ST_RD_EMPTY]  = rd_empty_i;
        status_word_o[i2c_host_pkg::ST_RD_FULL]   = rd_full_i;
    end

endmodule

`default_nettype wire

// ==== verilog/wb_reg_ctrl.sv ====
// Host bus register control for the I2C host block
// Decode, acknowledge, readback, prescale and command registers
// Push, pop and clear strobes toward the FIFOs and flags
`timescale 1ns/1ps
`default_nettype none

module wb_reg_ctrl #(
    parameter i2c_host_pkg::reg_word_t DEFAULT_PRESCALE = 16'd1
) (
    input  wire logic               clk,
    input  wire logic               rst,

    // Host bus
    input  wire logic [2:0]         wbs_adr_i,
    input  wire logic [15:0]        wbs_dat_i,
    output logic [15:0]             wbs_dat_o,
    input  wire logic               wbs_we_i,
    input  wire logic [1:0]         wbs_sel_i,
    input  wire logic               wbs_stb_i,
    input  wire logic               wbs_cyc_i,
    output logic                    wbs_ack_o,

    // Readback sources
    input  i2c_host_pkg::reg_word_t status_word_i,
    input  i2c_host_pkg::data_t     rd_entry_i,
    input  wire logic               rd_valid_i,

    // FIFO strobes
    output logic                    cmd_push_o,
    output i2c_host_pkg::cmd_t      cmd_entry_o,
    output logic                    wr_push_o,
    output i2c_host_pkg::data_t     wr_entry_o,
    output logic                    rd_pop_o,

    output i2c_host_pkg::reg_word_t prescale_o,

    // Write-one clears
    output logic                    clr_miss_ack_o,
    output logic                    clr_cmd_ovf_o,
    output logic                    clr_wr_ovf_o
);

    i2c_host_pkg::cmd_t      cmd_q;
    i2c_host_pkg::cmd_t      cmd_next;
    i2c_host_pkg::reg_word_t rd_word;
    logic                    access;
    logic                    wr_access;
    logic                    rd_access;
    logic                    cmd_wr;
    logic                    any_flag;

    // First cycle of a live access, ack rises at the next edge
    assign access    = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;
    assign wr_access = access && wbs_we_i;
    assign rd_access = access && !wbs_we_i;
    assign cmd_wr    = wr_access && (wbs_adr_i == i2c_host_pkg::REG_COMMAND);

    // New command from the enabled bytes, rest from the held copy
    always_comb begin
        cmd_next = cmd_q;
        if (wbs_sel_i[0]) begin
            cmd_next.address = wbs_dat_i[6:0];
        end
        if (wbs_sel_i[1]) begin
            cmd_next.start          = wbs_dat_i[i2c_host_pkg::CMD_START];
            cmd_next.read           = wbs_dat_i[i2c_host_pkg::CMD_READ];
            cmd_next.write          = wbs_dat_i[i2c_host_pkg::CMD_WRITE];
            cmd_next.write_multiple = wbs_dat_i[i2c_host_pkg::CMD_WR_M];
            cmd_next.stop           = wbs_dat_i[i2c_host_pkg::CMD_STOP];
        end
    end

    assign any_flag = cmd_next.start || cmd_next.read || cmd_next.write
                   || cmd_next.write_multiple || cmd_next.stop;

    // Flag byte triggers the push, an all-zero command is ignored
    assign cmd_push_o  = cmd_wr && wbs_sel_i[1] && any_flag;
    assign cmd_entry_o = cmd_next;

    // Data write needs the low byte, last only on a full word write
    assign wr_push_o       = wr_access && (wbs_adr_i == i2c_host_pkg::REG_DATA) && wbs_sel_i[0];
    assign wr_entry_o.data = wbs_dat_i[7:0];
    assign wr_entry_o.last = wbs_sel_i[1] && wbs_dat_i[i2c_host_pkg::DATA_LAST];

    // Status clears land on the ack edge
    assign clr_miss_ack_o = wr_access && (wbs_adr_i == i2c_host_pkg::REG_STATUS)
                         && wbs_sel_i[0] && wbs_dat_i[i2c_host_pkg::ST_MISS_ACK];
    assign clr_cmd_ovf_o  = wr_access && (wbs_adr_i == i2c_host_pkg::REG_STATUS)
                         && wbs_sel_i[1] && wbs_dat_i[i2c_host_pkg::ST_CMD_OVF];
    assign clr_wr_ovf_o   = wr_access && (wbs_adr_i == i2c_host_pkg::REG_STATUS)
                         && wbs_sel_i[1] && wbs_dat_i[i2c_host_pkg::ST_WR_OVF];

    // Readback mux, sampled into wbs_dat_o with the ack
    always_comb begin
        rd_word = '0;
        case (wbs_adr_i)
            i2c_host_pkg::REG_STATUS: begin
                rd_word = status_word_i;
            end
            i2c_host_pkg::REG_COMMAND: begin
                rd_word[6:0]                     = cmd_q.address;
                rd_word[i2c_host_pkg::CMD_START] = cmd_q.start;
                rd_word[i2c_host_pkg::CMD_READ]  = cmd_q.read;
                rd_word[i2c_host_pkg::CMD_WRITE] = cmd_q.write;
                rd_word[i2c_host_pkg::CMD_WR_M]  = cmd_q.write_multiple;
                rd_word[i2c_host_pkg::CMD_STOP]  = cmd_q.stop;
            end
            i2c_host_pkg::REG_DATA: begin
                // Valid bit tells software whether the byte is real
                rd_word[7:0]                      = rd_entry_i.data;
                rd_word[i2c_host_pkg::DATA_VALID] = rd_valid_i;
                rd_word[i2c_host_pkg::DATA_LAST]  = rd_entry_i.last;
            end
            i2c_host_pkg::REG_PRESCALE: begin
                rd_word = prescale_o;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_access) begin
            wbs_dat_o <= rd_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wbs_ack_o  <= 1'b0;
            rd_pop_o   <= 1'b0;
            cmd_q      <= '0;
            prescale_o <= DEFAULT_PRESCALE;
        end else begin
            // Toggling ack, one access every two cycles
            wbs_ack_o <= wbs_cyc_i && wbs_stb_i && !wbs_ack_o;
            // Pop during the ack cycle, after the byte was sampled
            rd_pop_o  <= rd_access && (wbs_adr_i == i2c_host_pkg::REG_DATA)
                      && wbs_sel_i[0] && rd_valid_i;
            if (cmd_wr) begin
                cmd_q <= cmd_next;
            end
            if (wr_access && (wbs_adr_i == i2c_host_pkg::REG_PRESCALE)) begin
                if (wbs_sel_i[0]) begin
                    prescale_o[7:0] <= wbs_dat_i[7:0];
                end
                if (wbs_sel_i[1]) begin
                    prescale_o[15:8] <= wbs_dat_i[15:8];
                end
            end
        end
    end

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst) wbs_ack_o |=> !wbs_ack_o
    );

    a_push_width: assert property (
        @(posedge clk) disable iff (rst) (cmd_push_o || wr_push_o) |=> !(cmd_push_o || wr_push_o)
    );

endmodule

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
// Synchronous FIFO with a payload type parameter
// Push side drops entries when full, pop side is a valid/ready stream
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     push_i,
    input  payload_t      data_i,
    output payload_t      data_o,
    output logic          valid_o,
    input  wire logic     ready_i,
    output logic          full_o,
    output logic          empty_o,
    output logic          overflow_o
);

    // DEPTH is a power of two so pointers wrap on their own
    localparam int PTR_W = $clog2(DEPTH);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               do_push;
    logic               do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == (PTR_W+1)'(DEPTH));
    assign valid_o = !empty_o;
    assign data_o  = mem[rd_ptr];

    // A push into a full FIFO is lost
    assign do_push    = push_i && !full_o;
    assign do_pop     = valid_o && ready_i;
    assign overflow_o = push_i && full_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy bound over the whole push and pop history
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= (PTR_W+1)'(DEPTH)
    );

endmodule

`default_nettype wire

// ==== verilog/i2c_host_pkg.sv ====
// Shared definitions for the I2C host register block
// Register offsets, status and command bit positions, payload types
`default_nettype none

package i2c_host_pkg;

    // Word offsets on the 3-bit host address bus
    localparam logic [2:0] REG_STATUS   = 3'd0;
    localparam logic [2:0] REG_COMMAND  = 3'd2;
    localparam logic [2:0] REG_DATA     = 3'd4;
    localparam logic [2:0] REG_PRESCALE = 3'd6;

    // Status word layout
    localparam int ST_BUSY      = 0;
    localparam int ST_BUS_CONT  = 1;
    localparam int ST_BUS_ACT   = 2;
    localparam int ST_MISS_ACK  = 3;
    localparam int ST_CMD_EMPTY = 8;
    localparam int ST_CMD_FULL  = 9;
    localparam int ST_CMD_OVF   = 10;
    localparam int ST_WR_EMPTY  = 11;
    localparam int ST_WR_FULL   = 12;
    localparam int ST_WR_OVF    = 13;
    localparam int ST_RD_EMPTY  = 14;
    localparam int ST_RD_FULL   = 15;

    // Command register flags, address sits in bits 6..0
    localparam int CMD_START = 8;
    localparam int CMD_READ  = 9;
    localparam int CMD_WRITE = 10;
    localparam int CMD_WR_M  = 11;
    localparam int CMD_STOP  = 12;

    // Data register flags, byte sits in bits 7..0
    localparam int DATA_VALID = 8;
    localparam int DATA_LAST  = 9;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 7;
    localparam int BYTE_W = 8;

    typedef logic [WORD_W-1:0] reg_word_t;
    typedef logic [ADDR_W-1:0] i2c_addr_t;

    // One queued bus engine command
    typedef struct packed {
        i2c_addr_t address;
        logic      start;
        logic      read;
        logic      write;
        logic      write_multiple;
        logic      stop;
    } cmd_t;

    // One byte on the write or read stream
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              last;
    } data_t;

endpackage

`default_nettype wire
